/* noc_params.svh */
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// virtual channels per input port
`define NOC_V 4

// flit slots in each VC buffer
`define NOC_B 4

// flit payload width
`define NOC_FPAY 32

// router address fields, x sits in the low bits of a header payload
`define NOC_AXW 3
`define NOC_AYW 3

// mesh router ports: local plus four directions
`define NOC_PORTS 5

`endif

/* noc_pkg.sv */
`include "noc_params.svh"

package noc_pkg;

    typedef logic [`NOC_V-1:0]    vc_mask_t;   // one bit per VC
    typedef logic [`NOC_FPAY-1:0] payload_t;
    typedef logic [`NOC_AXW-1:0]  coord_x_t;
    typedef logic [`NOC_AYW-1:0]  coord_y_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } router_addr_t;

    // output port encoding of a mesh router
    typedef enum logic [$clog2(`NOC_PORTS)-1:0] {
        PORT_LOCAL = 0,
        PORT_EAST  = 1,
        PORT_NORTH = 2,
        PORT_WEST  = 3,
        PORT_SOUTH = 4
    } port_id_t;

    typedef struct packed {
        logic     hdr;
        logic     tail;
        vc_mask_t vc;       // one-hot
        payload_t payload;
    } flit_t;

    typedef logic [$clog2(`NOC_B)-1:0]   buf_ptr_t;
    typedef logic [$clog2(`NOC_B+1)-1:0] buf_cnt_t;   // needs to hold B itself

endpackage

/* xy_route_compute.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module xy_route_compute (
    input  noc_pkg::router_addr_t current_addr_i,
    input  noc_pkg::flit_t        flit_i,
    input  logic                  flit_we_i,
    output noc_pkg::vc_mask_t     hdr_wr_o,
    output noc_pkg::port_id_t     route_o
);

    noc_pkg::router_addr_t dest_addr;
    logic                  hdr_write;
    logic                  x_greater;
    logic                  x_less;
    logic                  y_greater;
    logic                  y_less;

    // destination lives in the low payload bits of a header, x first
    assign dest_addr.x = flit_i.payload[`NOC_AXW-1:0];
    assign dest_addr.y = flit_i.payload[`NOC_AXW+`NOC_AYW-1:`NOC_AXW];

    assign hdr_write = flit_we_i & flit_i.hdr;

    // one-hot strobe into the route register of the target VC
    assign hdr_wr_o = hdr_write ? flit_i.vc : '0;

    // coordinate compares, unsigned, no wraparound in a mesh
    assign x_greater = dest_addr.x > current_addr_i.x;
    assign x_less    = dest_addr.x < current_addr_i.x;
    assign y_greater = dest_addr.y > current_addr_i.y;
    assign y_less    = dest_addr.y < current_addr_i.y;

    // dimension order: resolve x first, then y
    always_comb begin
        if (x_greater) begin
            route_o = noc_pkg::PORT_EAST;
        end else if (x_less) begin
            route_o = noc_pkg::PORT_WEST;
        end else if (y_greater) begin
            route_o = noc_pkg::PORT_NORTH;
        end else if (y_less) begin
            route_o = noc_pkg::PORT_SOUTH;
        end else begin
            route_o = noc_pkg::PORT_LOCAL;    // arrived
        end
    end

endmodule

/* vc_flit_buffer.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module vc_flit_buffer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  noc_pkg::flit_t                        flit_i,
    input  logic                                  flit_we_i,
    input  noc_pkg::vc_mask_t                     hdr_wr_i,
    input  noc_pkg::port_id_t                     route_i,
    input  noc_pkg::vc_mask_t                     grant_i,
    output noc_pkg::flit_t    [`NOC_V-1:0]        front_flit_o,
    output noc_pkg::vc_mask_t                     ivc_request_o,
    output noc_pkg::port_id_t [`NOC_V-1:0]        dest_port_o,
    output noc_pkg::vc_mask_t                     flit_is_tail_o
);

    // circular pointer advance, wraps at buffer depth
    function automatic noc_pkg::buf_ptr_t ptr_inc(input noc_pkg::buf_ptr_t ptr);
        noc_pkg::buf_ptr_t nxt;
        if (ptr == noc_pkg::buf_ptr_t'(`NOC_B-1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    for (genvar v = 0; v < `NOC_V; v++) begin : g_vc

        noc_pkg::flit_t    mem [`NOC_B];
        noc_pkg::buf_ptr_t rd_ptr;
        noc_pkg::buf_ptr_t wr_ptr;
        noc_pkg::buf_cnt_t count;
        noc_pkg::port_id_t route_q;
        logic              push;
        logic              pop;
        logic              not_empty;

        assign push = flit_we_i & flit_i.vc[v];   // upstream never overfills
        assign pop  = grant_i[v];                 // grant only hits a requesting VC

        // flit storage
        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= flit_i;
            end
        end

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (pop) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                unique case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;   // idle or push with pop
                endcase
            end
        end

        // route of the packet in flight on this VC
        // a new header only enters an empty VC, so this holds until the tail leaves
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                route_q <= noc_pkg::PORT_LOCAL;
            end else if (hdr_wr_i[v]) begin
                route_q <= route_i;
            end
        end

        assign not_empty = count != '0;

        // first-word fall-through view
        assign front_flit_o[v]   = mem[rd_ptr];
        assign ivc_request_o[v]  = not_empty;
        assign flit_is_tail_o[v] = not_empty & front_flit_o[v].tail;
        assign dest_port_o[v]    = route_q;

    end

endmodule

/* flit_out_update.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module flit_out_update (
    input  logic                           clk,
    input  logic                           reset,
    input  noc_pkg::flit_t [`NOC_V-1:0]    front_flit_i,
    input  noc_pkg::vc_mask_t              grant_i,
    input  noc_pkg::vc_mask_t              assigned_ovc_i,
    output noc_pkg::flit_t                 flit_o,
    output logic                           flit_valid_o
);

    localparam int FLIT_W = $bits(noc_pkg::flit_t);

    logic [FLIT_W-1:0] mux_bits;
    noc_pkg::flit_t    granted_flit;
    noc_pkg::flit_t    flit_next;
    logic              any_grant;

    // and-or mux, grant is one-hot or zero
    always_comb begin
        mux_bits = '0;
        for (int v = 0; v < `NOC_V; v++) begin
            mux_bits = mux_bits | (front_flit_i[v] & {FLIT_W{grant_i[v]}});
        end
    end

    assign granted_flit = noc_pkg::flit_t'(mux_bits);
    assign any_grant    = |grant_i;

    // downstream VC replaces the input VC, rest of the flit untouched
    always_comb begin
        flit_next    = granted_flit;
        flit_next.vc = assigned_ovc_i;
    end

    always_ff @(posedge clk) begin
        if (any_grant) begin
            flit_o <= flit_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid_o <= 1'b0;
        end else begin
            flit_valid_o <= any_grant;   // one cycle after the grant
        end
    end

endmodule

/* input_port.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module input_port (
    input  logic                                  clk,
    input  logic                                  reset,
    input  noc_pkg::router_addr_t                 current_addr_i,
    input  noc_pkg::flit_t                        flit_i,
    input  logic                                  flit_we_i,
    input  noc_pkg::vc_mask_t                     grant_i,
    input  noc_pkg::vc_mask_t                     assigned_ovc_i,
    output noc_pkg::vc_mask_t                     ivc_request_o,
    output noc_pkg::port_id_t [`NOC_V-1:0]        dest_port_o,
    output noc_pkg::vc_mask_t                     flit_is_tail_o,
    output noc_pkg::flit_t                        flit_o,
    output logic                                  flit_valid_o
);

    noc_pkg::vc_mask_t              hdr_wr;
    noc_pkg::port_id_t              route;
    noc_pkg::flit_t [`NOC_V-1:0]    front_flit;

    // header decode and XY route, same cycle as the write
    xy_route_compute xy_route (
        .current_addr_i (current_addr_i),
        .flit_i         (flit_i),
        .flit_we_i      (flit_we_i),
        .hdr_wr_o       (hdr_wr),
        .route_o        (route)
    );

    vc_flit_buffer flit_buffer (
        .clk            (clk),
        .reset          (reset),
        .flit_i         (flit_i),
        .flit_we_i      (flit_we_i),
        .hdr_wr_i       (hdr_wr),
        .route_i        (route),
        .grant_i        (grant_i),
        .front_flit_o   (front_flit),
        .ivc_request_o  (ivc_request_o),
        .dest_port_o    (dest_port_o),
        .flit_is_tail_o (flit_is_tail_o)
    );

    // granted flit out, one cycle later
    flit_out_update flit_update (
        .clk            (clk),
        .reset          (reset),
        .front_flit_i   (front_flit),
        .grant_i        (grant_i),
        .assigned_ovc_i (assigned_ovc_i),
        .flit_o         (flit_o),
        .flit_valid_o   (flit_valid_o)
    );

endmodule

/* input_port_assertions.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module input_port_assertions (
    input logic              clk,
    input logic              reset,
    input noc_pkg::flit_t    flit_i,
    input logic              flit_we_i,
    input noc_pkg::vc_mask_t grant_i,
    input noc_pkg::vc_mask_t ivc_request_i,
    input logic              flit_valid_i
);

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant_i))
        else $error("grant is not one-hot or zero");

    a_grant_requested: assert property (@(posedge clk) disable iff (reset)
        (grant_i & ~ivc_request_i) == '0)
        else $error("grant given to a VC without a request");

    a_valid_after_grant: assert property (@(posedge clk) disable iff (reset)
        (|grant_i) |=> flit_valid_i)
        else $error("no output flit one cycle after a grant");

    // shadow fill level per VC
    for (genvar v = 0; v < `NOC_V; v++) begin : g_vc
        noc_pkg::buf_cnt_t fill;
        logic              push;
        logic              pop;

        assign push = flit_we_i & flit_i.vc[v];
        assign pop  = grant_i[v];

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                fill <= '0;
            end else if (push & ~pop) begin
                fill <= fill + noc_pkg::buf_cnt_t'(1);
            end else if (pop & ~push) begin
                fill <= fill - noc_pkg::buf_cnt_t'(1);
            end
        end

        a_no_overflow: assert property (@(posedge clk) disable iff (reset)
            push |-> fill < noc_pkg::buf_cnt_t'(`NOC_B))
            else $error("write into full VC %0d", v);
    end

endmodule

bind input_port input_port_assertions input_port_assertions_i (
    .clk           (clk),
    .reset         (reset),
    .flit_i        (flit_i),
    .flit_we_i     (flit_we_i),
    .grant_i       (grant_i),
    .ivc_request_i (ivc_request_o),
    .flit_valid_i  (flit_valid_o)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int PERIOD = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // held for three rising edges, released just after the third
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module tb_checker (
    input  logic                           clk,
    input  logic                           reset,
    input  int                             test_id_i,
    input  logic                           test_end_i,
    input  noc_pkg::vc_mask_t              ivc_request_i,
    input  noc_pkg::port_id_t [`NOC_V-1:0] dest_port_i,
    input  noc_pkg::vc_mask_t              flit_is_tail_i,
    input  noc_pkg::flit_t                 flit_i,
    input  logic                           flit_valid_i,
    input  noc_pkg::vc_mask_t              exp_req_i,
    input  noc_pkg::vc_mask_t              exp_tail_i,
    input  noc_pkg::port_id_t [`NOC_V-1:0] exp_route_i,
    input  noc_pkg::flit_t                 exp_flit_i,
    input  logic                           exp_valid_i,
    output int                             error_count_o,
    output int                             tests_run_o,
    output int                             tests_failed_o
);

    int errors      = 0;
    int test_errors = 0;   // mismatches inside the running test
    int run         = 0;
    int failed      = 0;

    assign error_count_o  = errors;
    assign tests_run_o    = run;
    assign tests_failed_o = failed;

    function automatic string test_name(input int id);
        string name;
        case (id)
            0:       name = "reset_state";
            1:       name = "routing";
            2:       name = "ordering";
            3:       name = "vc_rewrite";
            4:       name = "request_tail";
            5:       name = "back_pressure";
            default: name = "unknown";
        endcase
        return name;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("mismatch in test %s: %s expected %0h actual %0h",
                 test_name(test_id_i), sig, exp_v, act_v);
        test_errors++;
        errors++;
    endtask

    // outputs settle after the rising edge, so compare in the middle of the cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (ivc_request_i !== exp_req_i) begin
                report_mismatch("ivc_request_o", 64'(exp_req_i), 64'(ivc_request_i));
            end
            if (flit_is_tail_i !== exp_tail_i) begin
                report_mismatch("flit_is_tail_o", 64'(exp_tail_i), 64'(flit_is_tail_i));
            end
            // route registers keep their value between packets
            for (int v = 0; v < `NOC_V; v++) begin
                if (dest_port_i[v] !== exp_route_i[v]) begin
                    report_mismatch($sformatf("dest_port_o[%0d]", v),
                                    64'(exp_route_i[v]), 64'(dest_port_i[v]));
                end
            end
            if (flit_valid_i !== exp_valid_i) begin
                report_mismatch("flit_valid_o", 64'(exp_valid_i), 64'(flit_valid_i));
            end
            if (exp_valid_i && flit_i !== exp_flit_i) begin
                report_mismatch("flit_o", 64'(exp_flit_i), 64'(flit_i));
            end
            if (test_end_i) begin
                run++;
                if (test_errors == 0) begin
                    $display("test %s passed", test_name(test_id_i));
                end else begin
                    failed++;
                    $display("test %s failed with %0d mismatches",
                             test_name(test_id_i), test_errors);
                end
                test_errors = 0;
            end
        end
    end

endmodule

/* tb_input_port.sv */
`timescale 1ns/1ps
`include "noc_params.svh"

module tb_input_port;

    localparam int WAIT_LIMIT = 300;   // cycles any wait loop may take

    logic                           clk;
    logic                           reset;
    noc_pkg::router_addr_t          current_addr;
    noc_pkg::flit_t                 flit_in;
    logic                           flit_we;
    noc_pkg::vc_mask_t              grant;
    noc_pkg::vc_mask_t              assigned_ovc;
    noc_pkg::vc_mask_t              ivc_request;
    noc_pkg::port_id_t [`NOC_V-1:0] dest_port;
    noc_pkg::vc_mask_t              flit_is_tail;
    noc_pkg::flit_t                 flit_out;
    logic                           flit_valid;

    // reference model, state as seen after the latest rising edge
    noc_pkg::flit_t                 exp_q [`NOC_V][$];
    noc_pkg::port_id_t [`NOC_V-1:0] exp_route;
    noc_pkg::vc_mask_t              exp_req;
    noc_pkg::vc_mask_t              exp_tail;
    noc_pkg::flit_t                 exp_flit;    // granted at the latest edge
    logic                           exp_valid;

    int   pkt_left [`NOC_V];   // flits still owed by the open packet of a VC
    int   test_id;
    logic test_end;
    int   error_count;
    int   tests_run;
    int   tests_failed;
    logic run_ok;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    input_port input_port_i (
        .clk            (clk),
        .reset          (reset),
        .current_addr_i (current_addr),
        .flit_i         (flit_in),
        .flit_we_i      (flit_we),
        .grant_i        (grant),
        .assigned_ovc_i (assigned_ovc),
        .ivc_request_o  (ivc_request),
        .dest_port_o    (dest_port),
        .flit_is_tail_o (flit_is_tail),
        .flit_o         (flit_out),
        .flit_valid_o   (flit_valid)
    );

    tb_checker result_check (
        .clk (clk), .reset (reset), .test_id_i (test_id), .test_end_i (test_end),
        .ivc_request_i (ivc_request), .dest_port_i (dest_port),
        .flit_is_tail_i (flit_is_tail), .flit_i (flit_out), .flit_valid_i (flit_valid),
        .exp_req_i (exp_req), .exp_tail_i (exp_tail), .exp_route_i (exp_route),
        .exp_flit_i (exp_flit), .exp_valid_i (exp_valid),
        .error_count_o (error_count), .tests_run_o (tests_run),
        .tests_failed_o (tests_failed)
    );

    function automatic int vc_index(input noc_pkg::vc_mask_t mask);
        int idx;
        idx = 0;
        for (int v = 0; v < `NOC_V; v++) begin
            if (mask[v]) begin
                idx = v;
            end
        end
        return idx;
    endfunction

    // dimension order routing, x settled before y
    function automatic noc_pkg::port_id_t xy_route(input noc_pkg::router_addr_t cur,
                                                   input noc_pkg::payload_t pay);
        noc_pkg::coord_x_t dst_x;
        noc_pkg::coord_y_t dst_y;
        noc_pkg::port_id_t port;
        dst_x = pay[`NOC_AXW-1:0];
        dst_y = pay[`NOC_AXW+`NOC_AYW-1:`NOC_AXW];
        if (int'(dst_x) > int'(cur.x)) begin
            port = noc_pkg::PORT_EAST;
        end else if (int'(dst_x) < int'(cur.x)) begin
            port = noc_pkg::PORT_WEST;
        end else if (int'(dst_y) > int'(cur.y)) begin
            port = noc_pkg::PORT_NORTH;
        end else if (int'(dst_y) < int'(cur.y)) begin
            port = noc_pkg::PORT_SOUTH;
        end else begin
            port = noc_pkg::PORT_LOCAL;
        end
        return port;
    endfunction

    function automatic logic busy();
        logic open_pkt;
        open_pkt = 1'b0;
        for (int v = 0; v < `NOC_V; v++) begin
            open_pkt = open_pkt | (pkt_left[v] != 0);
        end
        return open_pkt || exp_req != '0 || exp_valid;
    endfunction

    function automatic logic all_full();
        logic full;
        full = 1'b1;
        for (int v = 0; v < `NOC_V; v++) begin
            full = full & (noc_pkg::buf_cnt_t'(exp_q[v].size()) == noc_pkg::buf_cnt_t'(`NOC_B));
        end
        return full;
    endfunction

    // applies the inputs the DUT sampled at this edge
    task automatic model_update();
        int             v;
        noc_pkg::flit_t f;
        exp_valid = 1'b0;
        if (grant != '0) begin
            v         = vc_index(grant);
            f         = exp_q[v].pop_front();
            f.vc      = assigned_ovc;
            exp_flit  = f;
            exp_valid = 1'b1;
        end
        if (flit_we) begin
            v = vc_index(flit_in.vc);
            exp_q[v].push_back(flit_in);
            if (flit_in.hdr) begin
                exp_route[v] = xy_route(current_addr, flit_in.payload);
            end
        end
        for (int i = 0; i < `NOC_V; i++) begin
            exp_req[i]  = exp_q[i].size() != 0;
            exp_tail[i] = exp_req[i] && exp_q[i][0].tail;
        end
    endtask

    task automatic drive_cycle(input noc_pkg::flit_t f, input logic we,
                               input noc_pkg::vc_mask_t g, input noc_pkg::vc_mask_t ovc);
        flit_in      = f;
        flit_we      = we;
        grant        = g;
        assigned_ovc = ovc;
        @(posedge clk);
        model_update();
        #1;
    endtask

    // max_len of zero only finishes open packets
    task automatic random_cycle(input int write_pct, input int grant_pct,
                                input int min_len, input int max_len);
        noc_pkg::flit_t    f;
        noc_pkg::vc_mask_t g;
        noc_pkg::vc_mask_t ovc;
        logic              we;
        int                start;
        int                v;
        f   = '0;
        g   = '0;
        we  = 1'b0;
        ovc = noc_pkg::vc_mask_t'(1) << $urandom_range(`NOC_V-1);
        if ($urandom_range(99) < write_pct) begin
            start = $urandom_range(`NOC_V-1);
            for (int i = 0; i < `NOC_V && !we; i++) begin
                v = (start + i) % `NOC_V;
                if (exp_q[v].size() < `NOC_B &&
                    (pkt_left[v] != 0 || (max_len > 0 && exp_q[v].size() == 0))) begin
                    we        = 1'b1;
                    f.vc      = noc_pkg::vc_mask_t'(1) << v;
                    f.payload = noc_pkg::payload_t'($urandom);   // header: random destination
                    if (pkt_left[v] == 0) begin
                        pkt_left[v] = $urandom_range(max_len, min_len);
                        f.hdr       = 1'b1;
                    end
                    pkt_left[v]--;
                    f.tail = pkt_left[v] == 0;
                end
            end
        end
        if (exp_req != '0 && $urandom_range(99) < grant_pct) begin
            start = $urandom_range(`NOC_V-1);
            for (int i = 0; i < `NOC_V && g == '0; i++) begin
                v = (start + i) % `NOC_V;
                if (exp_req[v]) begin
                    g[v] = 1'b1;
                end
            end
        end
        drive_cycle(f, we, g, ovc);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (busy() && n < WAIT_LIMIT) begin
            random_cycle(100, 100, 0, 0);
            n++;
        end
        if (busy()) begin
            $display("timeout: flits still buffered or packets still open after %0d cycles",
                     WAIT_LIMIT);
            run_ok = 1'b0;
        end
    endtask

    task automatic end_test();
        test_end = 1'b1;
        drive_cycle('0, 1'b0, '0, '0);
        test_end = 1'b0;
    endtask

    task automatic run_test(input int id, input int cycles, input int write_pct,
                            input int grant_pct, input int min_len, input int max_len);
        test_id          = id;
        current_addr.x   = noc_pkg::coord_x_t'($urandom_range((1 << `NOC_AXW) - 1));
        current_addr.y   = noc_pkg::coord_y_t'($urandom_range((1 << `NOC_AYW) - 1));
        repeat (cycles) begin
            random_cycle(write_pct, grant_pct, min_len, max_len);
        end
        drain();
        if (run_ok) begin
            end_test();
        end
    endtask

    task automatic run_back_pressure();
        int n;
        test_id = 5;
        n       = 0;
        while (!all_full() && n < WAIT_LIMIT) begin
            random_cycle(100, 0, `NOC_B, `NOC_B);
            n++;
        end
        if (!all_full()) begin
            $display("timeout: VC buffers never filled up while grants were held back");
            run_ok = 1'b0;
        end else begin
            repeat (5) drive_cycle('0, 1'b0, '0, '0);   // stall, nothing may leave
            drain();
            if (run_ok) begin
                end_test();
            end
        end
    endtask

    initial begin
        int n;
        void'($urandom(17));
        current_addr = '0;
        flit_in      = '0;
        flit_we      = 1'b0;
        grant        = '0;
        assigned_ovc = '0;
        test_id      = 0;
        test_end     = 1'b0;
        exp_req      = '0;
        exp_tail     = '0;
        exp_flit     = '0;
        exp_valid    = 1'b0;
        for (int v = 0; v < `NOC_V; v++) begin
            exp_route[v] = noc_pkg::PORT_LOCAL;
            pkt_left[v]  = 0;
        end
        n = 0;
        while (reset !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        run_ok = reset === 1'b0;
        if (!run_ok) begin
            $display("timeout: reset was never released");
        end else begin
            #1;
            repeat (3) drive_cycle('0, 1'b0, '0, '0);
            end_test();
        end
        if (run_ok) begin
            run_test(1, 200, 40, 50, 1, 1);   // single-flit packets
        end
        if (run_ok) begin
            run_test(2, 400, 70, 40, 1, 4);
        end
        if (run_ok) begin
            run_test(3, 300, 60, 90, 1, 4);   // dense grants, back-to-back output
        end
        if (run_ok) begin
            run_test(4, 300, 50, 50, 1, 2);
        end
        if (run_ok) begin
            run_back_pressure();
        end
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
                 error_count);
        if (run_ok && tests_failed == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
noc_pkg.sv
xy_route_compute.sv
vc_flit_buffer.sv
flit_out_update.sv
input_port.sv
input_port_assertions.sv
tb_clock_gen.sv
tb_checker.sv
tb_input_port.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_input_port
FLIST = list.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
